//--- include/axi_define.svh
`ifndef AXI_DEFINE_SVH
`define AXI_DEFINE_SVH

// Write channel bus widths

`define AXI_ADDR_BITS 32

`define AXI_DATA_BITS 32

// One strobe bit per data byte
`define AXI_STRB_BITS 4

`define AXI_ID_BITS 4

`define AXI_RESP_BITS 2

`endif

//--- design/axi_pkg.sv
`default_nettype none

`include "axi_define.svh"

package axi_pkg;

  typedef logic [`AXI_ADDR_BITS-1:0] addr_t;
  typedef logic [`AXI_DATA_BITS-1:0] data_t;
  typedef logic [`AXI_STRB_BITS-1:0] strb_t;
  typedef logic [`AXI_ID_BITS-1:0]   id_t;
  typedef logic [`AXI_RESP_BITS-1:0] resp_t;

  // W arbiter state
  typedef enum logic {
    LOCK_FREE,
    LOCK_M1
  } addr_arb_lock_t;

  // Target slave of a burst
  typedef enum logic [1:0] {
    LOCK_NO,
    LOCK_S0,
    LOCK_S1,
    LOCK_S2
  } data_arb_lock_t;

  // Decode uses the two top address bits
  localparam int REGION_MSB = `AXI_ADDR_BITS - 1;
  localparam logic [1:0] REGION_S0 = 2'b00;
  localparam logic [1:0] REGION_S1 = 2'b01;

  function automatic data_arb_lock_t slave_of_addr(input addr_t addr);
    logic [1:0] region;
    region = addr[REGION_MSB -: 2];
    case (region)
      REGION_S0: return LOCK_S0;
      REGION_S1: return LOCK_S1;
      // Upper half of the map
      default:   return LOCK_S2;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- design/aw_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module aw_decoder (
  input  logic                     clk,
  input  logic                     rstn,
  input  axi_pkg::addr_t           awaddr_m1,
  input  logic                     awvalid_m1,
  output logic                     awready_m1,
  input  logic                     write_pending,
  output logic                     awvalid_s0,
  output logic                     awvalid_s1,
  output logic                     awvalid_s2,
  input  logic                     awready_s0,
  input  logic                     awready_s1,
  input  logic                     awready_s2,
  output axi_pkg::data_arb_lock_t  aw_lock
);

  import axi_pkg::*;

  logic aw_open;
  logic awready_sel;

  assign aw_lock = slave_of_addr(awaddr_m1);

  // New address held back while a write is outstanding
  assign aw_open = awvalid_m1 & ~write_pending;

  assign awvalid_s0 = aw_open & (aw_lock == LOCK_S0);
  assign awvalid_s1 = aw_open & (aw_lock == LOCK_S1);
  assign awvalid_s2 = aw_open & (aw_lock == LOCK_S2);

  always_comb begin
    case (aw_lock)
      LOCK_S0: awready_sel = awready_s0;
      LOCK_S1: awready_sel = awready_s1;
      LOCK_S2: awready_sel = awready_s2;
      default: awready_sel = 1'b0;
    endcase
  end

  assign awready_m1 = awready_sel & ~write_pending;

  a_aw_onehot: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot0({awvalid_s0, awvalid_s1, awvalid_s2})
  ) else $error("awvalid raised on more than one slave");

endmodule

`default_nettype wire

//--- design/w_router.sv
`timescale 1ns/10ps
`default_nettype none

module w_router (
  input  logic            clk,
  input  logic            rstn,
  // Master
  input  axi_pkg::data_t  wdata_m1,
  input  axi_pkg::strb_t  wstrb_m1,
  input  logic            wlast_m1,
  input  logic            wvalid_m1,
  output logic            wready_m1,
  input  logic            awvalid_m1,
  // Slave 0
  output axi_pkg::data_t  wdata_s0,
  output axi_pkg::strb_t  wstrb_s0,
  output logic            wlast_s0,
  output logic            wvalid_s0,
  input  logic            wready_s0,
  input  logic            awvalid_s0,
  input  logic            awready_s0,
  // Slave 1
  output axi_pkg::data_t  wdata_s1,
  output axi_pkg::strb_t  wstrb_s1,
  output logic            wlast_s1,
  output logic            wvalid_s1,
  input  logic            wready_s1,
  input  logic            awvalid_s1,
  input  logic            awready_s1,
  // Slave 2
  output axi_pkg::data_t  wdata_s2,
  output axi_pkg::strb_t  wstrb_s2,
  output logic            wlast_s2,
  output logic            wvalid_s2,
  input  logic            wready_s2,
  input  logic            awvalid_s2,
  input  logic            awready_s2
);

  import axi_pkg::*;

  addr_arb_lock_t addr_arb_lock;
  addr_arb_lock_t addr_arb_lock_next;
  data_arb_lock_t awx_slave_lock;
  data_arb_lock_t awx_slave_lock_r;
  data_arb_lock_t wx_slave_lock;

  logic fast_transaction;
  logic slow_transaction;
  logic wready_from_slave;
  logic aw_handshake;
  logic wlast_handshake;
  logic lock_entry;

  // Live target from the decoded AWVALID levels
  always_comb begin
    case ({awvalid_s0, awvalid_s1, awvalid_s2})
      3'b100:  awx_slave_lock = LOCK_S0;
      3'b010:  awx_slave_lock = LOCK_S1;
      3'b001:  awx_slave_lock = LOCK_S2;
      default: awx_slave_lock = LOCK_NO;
    endcase
  end

  assign aw_handshake = (awvalid_s0 & awready_s0) |
                        (awvalid_s1 & awready_s1) |
                        (awvalid_s2 & awready_s2);

  assign slow_transaction = (addr_arb_lock == LOCK_M1);
  assign fast_transaction = wvalid_m1 & awvalid_m1 & ~slow_transaction;

  // Outside a fast start the registered lock steers the beats
  assign wx_slave_lock = fast_transaction ? awx_slave_lock : awx_slave_lock_r;

  assign wlast_handshake = wvalid_m1 & wready_from_slave & wlast_m1;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      addr_arb_lock <= LOCK_FREE;
    end else begin
      addr_arb_lock <= addr_arb_lock_next;
    end
  end

  always_comb begin
    case (addr_arb_lock)
      LOCK_FREE: begin
        // Only lock once a real target exists
        if (wvalid_m1 && wx_slave_lock != LOCK_NO && !wlast_handshake) begin
          addr_arb_lock_next = LOCK_M1;
        end else begin
          addr_arb_lock_next = LOCK_FREE;
        end
      end
      LOCK_M1: addr_arb_lock_next = wlast_handshake ? LOCK_FREE : LOCK_M1;
      default: addr_arb_lock_next = LOCK_FREE;
    endcase
  end

  assign lock_entry = !slow_transaction && (addr_arb_lock_next == LOCK_M1);

  // Target kept from lock entry, or from the AW handshake when W lags
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      awx_slave_lock_r <= LOCK_NO;
    end else if (wlast_handshake) begin
      awx_slave_lock_r <= LOCK_NO;
    end else if (lock_entry) begin
      awx_slave_lock_r <= wx_slave_lock;
    end else if (aw_handshake && !slow_transaction) begin
      awx_slave_lock_r <= awx_slave_lock;
    end
  end

  always_comb begin
    wdata_s0  = '0;
    wstrb_s0  = '0;
    wlast_s0  = 1'b0;
    wvalid_s0 = 1'b0;
    wdata_s1  = '0;
    wstrb_s1  = '0;
    wlast_s1  = 1'b0;
    wvalid_s1 = 1'b0;
    wdata_s2  = '0;
    wstrb_s2  = '0;
    wlast_s2  = 1'b0;
    wvalid_s2 = 1'b0;
    case (wx_slave_lock)
      LOCK_S0: begin
        wdata_s0  = wdata_m1;
        wstrb_s0  = wstrb_m1;
        wlast_s0  = wlast_m1;
        wvalid_s0 = wvalid_m1;
      end
      LOCK_S1: begin
        wdata_s1  = wdata_m1;
        wstrb_s1  = wstrb_m1;
        wlast_s1  = wlast_m1;
        wvalid_s1 = wvalid_m1;
      end
      LOCK_S2: begin
        wdata_s2  = wdata_m1;
        wstrb_s2  = wstrb_m1;
        wlast_s2  = wlast_m1;
        wvalid_s2 = wvalid_m1;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (wx_slave_lock)
      LOCK_S0: wready_from_slave = wready_s0;
      LOCK_S1: wready_from_slave = wready_s1;
      LOCK_S2: wready_from_slave = wready_s2;
      default: wready_from_slave = 1'b0;
    endcase
  end

  assign wready_m1 = wready_from_slave;

  a_w_onehot: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot0({wvalid_s0, wvalid_s1, wvalid_s2})
  ) else $error("wvalid raised on more than one slave");

  // Stalled beat must wait with the same data
  a_w_hold: assert property (
    @(posedge clk) disable iff (!rstn)
    (wvalid_m1 && !wready_m1) |=> (wvalid_m1 && $stable(wdata_m1))
  ) else $error("wdata changed while the beat was stalled");

endmodule

`default_nettype wire

//--- design/b_return.sv
`timescale 1ns/10ps
`default_nettype none

module b_return (
  input  logic                     clk,
  input  logic                     rstn,
  input  axi_pkg::data_arb_lock_t  aw_lock,
  input  logic                     awvalid_m1,
  input  logic                     awready_m1,
  output axi_pkg::id_t             bid_m1,
  output axi_pkg::resp_t           bresp_m1,
  output logic                     bvalid_m1,
  input  logic                     bready_m1,
  input  axi_pkg::id_t             bid_s0,
  input  axi_pkg::resp_t           bresp_s0,
  input  logic                     bvalid_s0,
  output logic                     bready_s0,
  input  axi_pkg::id_t             bid_s1,
  input  axi_pkg::resp_t           bresp_s1,
  input  logic                     bvalid_s1,
  output logic                     bready_s1,
  input  axi_pkg::id_t             bid_s2,
  input  axi_pkg::resp_t           bresp_s2,
  input  logic                     bvalid_s2,
  output logic                     bready_s2,
  output logic                     write_pending
);

  import axi_pkg::*;

  data_arb_lock_t b_lock;
  logic aw_handshake;
  logic b_handshake;

  assign aw_handshake = awvalid_m1 & awready_m1;
  assign b_handshake  = bvalid_m1 & bready_m1;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      b_lock        <= LOCK_NO;
      write_pending <= 1'b0;
    end else if (b_handshake) begin
      b_lock        <= LOCK_NO;
      write_pending <= 1'b0;
    end else if (aw_handshake) begin
      b_lock        <= aw_lock;
      write_pending <= 1'b1;
    end
  end

  always_comb begin
    bid_m1    = '0;
    bresp_m1  = '0;
    bvalid_m1 = 1'b0;
    case (b_lock)
      LOCK_S0: begin
        bid_m1    = bid_s0;
        bresp_m1  = bresp_s0;
        bvalid_m1 = bvalid_s0;
      end
      LOCK_S1: begin
        bid_m1    = bid_s1;
        bresp_m1  = bresp_s1;
        bvalid_m1 = bvalid_s1;
      end
      LOCK_S2: begin
        bid_m1    = bid_s2;
        bresp_m1  = bresp_s2;
        bvalid_m1 = bvalid_s2;
      end
      default: ;
    endcase
  end

  // Ready only toward the slave that took the write
  assign bready_s0 = bready_m1 & (b_lock == LOCK_S0);
  assign bready_s1 = bready_m1 & (b_lock == LOCK_S1);
  assign bready_s2 = bready_m1 & (b_lock == LOCK_S2);

  a_b_pending: assert property (
    @(posedge clk) disable iff (!rstn)
    bvalid_m1 |-> write_pending
  ) else $error("bvalid reached the master with no write pending");

endmodule

`default_nettype wire

//--- design/axi_write_xbar.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_xbar (
  input  logic            clk,
  input  logic            rstn,
  // Master port
  input  axi_pkg::addr_t  awaddr_m1,
  input  axi_pkg::id_t    awid_m1,
  input  logic            awvalid_m1,
  output logic            awready_m1,
  input  axi_pkg::data_t  wdata_m1,
  input  axi_pkg::strb_t  wstrb_m1,
  input  logic            wlast_m1,
  input  logic            wvalid_m1,
  output logic            wready_m1,
  output axi_pkg::id_t    bid_m1,
  output axi_pkg::resp_t  bresp_m1,
  output logic            bvalid_m1,
  input  logic            bready_m1,
  // Slave 0
  output axi_pkg::addr_t  awaddr_s0,
  output axi_pkg::id_t    awid_s0,
  output logic            awvalid_s0,
  input  logic            awready_s0,
  output axi_pkg::data_t  wdata_s0,
  output axi_pkg::strb_t  wstrb_s0,
  output logic            wlast_s0,
  output logic            wvalid_s0,
  input  logic            wready_s0,
  input  axi_pkg::id_t    bid_s0,
  input  axi_pkg::resp_t  bresp_s0,
  input  logic            bvalid_s0,
  output logic            bready_s0,
  // Slave 1
  output axi_pkg::addr_t  awaddr_s1,
  output axi_pkg::id_t    awid_s1,
  output logic            awvalid_s1,
  input  logic            awready_s1,
  output axi_pkg::data_t  wdata_s1,
  output axi_pkg::strb_t  wstrb_s1,
  output logic            wlast_s1,
  output logic            wvalid_s1,
  input  logic            wready_s1,
  input  axi_pkg::id_t    bid_s1,
  input  axi_pkg::resp_t  bresp_s1,
  input  logic            bvalid_s1,
  output logic            bready_s1,
  // Slave 2
  output axi_pkg::addr_t  awaddr_s2,
  output axi_pkg::id_t    awid_s2,
  output logic            awvalid_s2,
  input  logic            awready_s2,
  output axi_pkg::data_t  wdata_s2,
  output axi_pkg::strb_t  wstrb_s2,
  output logic            wlast_s2,
  output logic            wvalid_s2,
  input  logic            wready_s2,
  input  axi_pkg::id_t    bid_s2,
  input  axi_pkg::resp_t  bresp_s2,
  input  logic            bvalid_s2,
  output logic            bready_s2
);

  import axi_pkg::*;

  data_arb_lock_t aw_lock;
  logic           write_pending;

  // Address and ID fan out, only AWVALID selects
  assign awaddr_s0 = awaddr_m1;
  assign awaddr_s1 = awaddr_m1;
  assign awaddr_s2 = awaddr_m1;
  assign awid_s0   = awid_m1;
  assign awid_s1   = awid_m1;
  assign awid_s2   = awid_m1;

  aw_decoder u_aw_decoder (.*);

  w_router u_w_router (.*);

  b_return u_b_return (.*);

endmodule

`default_nettype wire

//--- verif/xbar_checker.sv
`timescale 1ns/10ps
`default_nettype none

module xbar_checker (
  input  logic           clk,
  input  logic           rstn,
  input  axi_pkg::addr_t awaddr_m1,
  input  logic           awvalid_m1,
  input  logic           awready_m1,
  input  axi_pkg::strb_t wstrb_m1,
  input  logic           wlast_m1,
  input  logic           wvalid_m1,
  input  logic           wready_m1,
  input  axi_pkg::id_t   bid_m1,
  input  axi_pkg::resp_t bresp_m1,
  input  logic           bvalid_m1,
  input  logic           bready_m1,
  input  axi_pkg::addr_t awaddr_s0,
  input  axi_pkg::addr_t awaddr_s1,
  input  axi_pkg::addr_t awaddr_s2,
  input  axi_pkg::id_t   awid_s0,
  input  axi_pkg::id_t   awid_s1,
  input  axi_pkg::id_t   awid_s2,
  input  logic           awvalid_s0,
  input  logic           awvalid_s1,
  input  logic           awvalid_s2,
  input  logic           awready_s0,
  input  logic           awready_s1,
  input  logic           awready_s2,
  input  axi_pkg::data_t wdata_s0,
  input  axi_pkg::data_t wdata_s1,
  input  axi_pkg::data_t wdata_s2,
  input  axi_pkg::strb_t wstrb_s0,
  input  axi_pkg::strb_t wstrb_s1,
  input  axi_pkg::strb_t wstrb_s2,
  input  logic           wlast_s0,
  input  logic           wlast_s1,
  input  logic           wlast_s2,
  input  logic           wvalid_s0,
  input  logic           wvalid_s1,
  input  logic           wvalid_s2,
  input  logic           wready_s0,
  input  logic           wready_s1,
  input  logic           wready_s2,
  input  logic           bready_s0,
  input  logic           bready_s1,
  input  logic           bready_s2,
  input  logic           write_pending,
  output int             errors,
  output int             bursts_done
);

  import axi_pkg::*;

  localparam int FIELDS = 6;
  localparam int MAX_BURSTS = 32;

  logic [31:0] stim [0:FIELDS*MAX_BURSTS-1];
  int nb;
  int err_count = 0;
  int aw_count = 0;
  int w_count = 0;
  int b_count = 0;
  int beat = 0;
  int tgt [MAX_BURSTS];
  logic rstn_seen = 1'b0;
  logic [2:0] awv;
  logic [2:0] awr;
  logic [2:0] wv;
  logic [2:0] wr;
  logic [2:0] brd;

  assign awv = {awvalid_s2, awvalid_s1, awvalid_s0};
  assign awr = {awready_s2, awready_s1, awready_s0};
  assign wv  = {wvalid_s2, wvalid_s1, wvalid_s0};
  assign wr  = {wready_s2, wready_s1, wready_s0};
  assign brd = {bready_s2, bready_s1, bready_s0};
  assign errors = err_count;
  assign bursts_done = b_count;

  initial begin
    for (int i = 0; i < FIELDS * MAX_BURSTS; i++) begin
      stim[i] = '0;
    end
    $readmemh("verif/xbar_write_input.txt", stim);
    nb = 0;
    while (nb < MAX_BURSTS && stim[nb*FIELDS+1] != 0) begin
      nb++;
    end
  end

  function automatic int slave_index(input addr_t addr);
    case (slave_of_addr(addr))
      LOCK_S0: return 0;
      LOCK_S1: return 1;
      default: return 2;
    endcase
  endfunction

  function automatic addr_t awaddr_of(input int k);
    return (k == 0) ? awaddr_s0 : (k == 1) ? awaddr_s1 : awaddr_s2;
  endfunction

  function automatic id_t awid_of(input int k);
    return (k == 0) ? awid_s0 : (k == 1) ? awid_s1 : awid_s2;
  endfunction

  function automatic data_t wdata_of(input int k);
    return (k == 0) ? wdata_s0 : (k == 1) ? wdata_s1 : wdata_s2;
  endfunction

  function automatic strb_t wstrb_of(input int k);
    return (k == 0) ? wstrb_s0 : (k == 1) ? wstrb_s1 : wstrb_s2;
  endfunction

  function automatic logic wlast_of(input int k);
    return (k == 0) ? wlast_s0 : (k == 1) ? wlast_s1 : wlast_s2;
  endfunction

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      err_count++;
      $display("FAIL %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic complain(input string msg);
    err_count++;
    $display("ERROR: %s", msg);
  endtask

  always @(posedge clk) begin
    int w_tgt;
    int aw_tgt;
    int base;
    logic [2:0] exp_awv;
    logic [2:0] exp_wv;
    logic [2:0] exp_brd;
    if (!rstn || !rstn_seen) begin
      check_val("awvalid_s", 32'(3'b000), 32'(awv));
      check_val("wvalid_s", 32'(3'b000), 32'(wv));
      check_val("awready_m1", 32'(1'b0), 32'(awready_m1));
      check_val("wready_m1", 32'(1'b0), 32'(wready_m1));
      check_val("bvalid_m1", 32'(1'b0), 32'(bvalid_m1));
      check_val("write_pending", 32'(1'b0), 32'(write_pending));
    end else begin
      // AW goes to the decoded slave, and only with nothing outstanding
      exp_awv = 3'b000;
      aw_tgt = slave_index(awaddr_m1);
      if (awvalid_m1 && aw_count == b_count) begin
        exp_awv[aw_tgt] = 1'b1;
      end
      check_val("awvalid_s", 32'(exp_awv), 32'(awv));
      check_val("awready_m1", 32'((aw_count == b_count) ? awr[aw_tgt] : 1'b0),
                32'(awready_m1));

      if (w_count < aw_count) begin
        w_tgt = tgt[w_count];
      end else if (awvalid_m1 && aw_count == b_count) begin
        w_tgt = aw_tgt;
      end else begin
        w_tgt = -1;
      end
      exp_wv = 3'b000;
      if (w_tgt >= 0) begin
        exp_wv[w_tgt] = wvalid_m1;
      end
      check_val("wvalid_s", 32'(exp_wv), 32'(wv));
      check_val("wready_m1", 32'((w_tgt >= 0) ? wr[w_tgt] : 1'b0), 32'(wready_m1));

      exp_brd = 3'b000;
      if (b_count < aw_count) begin
        exp_brd[tgt[b_count]] = bready_m1;
      end
      check_val("bready_s", 32'(exp_brd), 32'(brd));

      if (awvalid_m1 && awready_m1) begin
        if (aw_count >= nb) begin
          complain("AW handshake beyond the last burst of the input file");
        end else begin
          check_val("awaddr_s", stim[aw_count*FIELDS], awaddr_of(aw_tgt));
          check_val("awid_s", 32'(aw_count % 16), 32'(awid_of(aw_tgt)));
          tgt[aw_count] = aw_tgt;
        end
        aw_count++;
      end

      if (wvalid_m1 && wready_m1 && w_tgt >= 0) begin
        base = w_count * FIELDS;
        check_val("wdata", stim[base+2] + 32'(beat), wdata_of(w_tgt));
        // Strobe from the file, or the random one the master picked
        if (stim[base+5] != 0) begin
          check_val("wstrb", stim[base+5], 32'(wstrb_of(w_tgt)));
        end else begin
          check_val("wstrb", 32'(wstrb_m1), 32'(wstrb_of(w_tgt)));
        end
        check_val("wlast", 32'(beat == int'(stim[base+1]) - 1), 32'(wlast_of(w_tgt)));
        if (wlast_m1) begin
          w_count++;
          beat = 0;
        end else begin
          beat++;
        end
      end

      if (bvalid_m1 && bready_m1) begin
        if (b_count >= aw_count) begin
          complain("B response arrived with no write outstanding");
        end else begin
          check_val("bresp_m1", stim[b_count*FIELDS+4], 32'(bresp_m1));
          check_val("bid_m1", 32'(b_count % 16), 32'(bid_m1));
        end
        b_count++;
      end
    end
    rstn_seen <= rstn;
  end

endmodule

`default_nettype wire

//--- verif/tb_axi_write_xbar.sv
`timescale 1ns/10ps
`default_nettype none

// Simple write slave with a WREADY stall mask and a delayed B response
module slave_model (
  input  logic           clk,
  input  logic           rstn,
  input  logic           awvalid,
  input  axi_pkg::id_t   awid,
  output logic           awready,
  input  logic           wvalid,
  input  logic           wlast,
  output logic           wready,
  output axi_pkg::id_t   bid,
  output axi_pkg::resp_t bresp,
  output logic           bvalid,
  input  logic           bready,
  input  logic [7:0]     stall_pattern,
  input  axi_pkg::resp_t resp_code
);

  import axi_pkg::*;

  id_t   id_q;
  resp_t resp_q;
  logic  awvalid_q;
  logic  wvalid_q;
  logic  last_hs;
  logic  b_hs;
  int    b_delay;
  int    stall_cnt;

  // Valids seen at the rising edge
  always @(posedge clk) begin
    awvalid_q <= awvalid;
    wvalid_q  <= wvalid;
    last_hs   <= wvalid && wready && wlast;
    b_hs      <= bvalid && bready;
    if (awvalid && awready) begin
      id_q   <= awid;
      resp_q <= resp_code;
    end
  end

  always @(negedge clk, negedge rstn) begin
    if (!rstn) begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      bid       <= '0;
      bresp     <= '0;
      b_delay   <= -1;
      stall_cnt <= 0;
    end else begin
      awready <= awvalid_q;
      wready  <= wvalid_q && !stall_pattern[stall_cnt % 8];
      if (last_hs) begin
        stall_cnt <= 0;
      end else if (wvalid_q) begin
        stall_cnt <= stall_cnt + 1;
      end
      if (b_hs) begin
        bvalid <= 1'b0;
      end
      // Response two cycles after the last beat
      if (last_hs) begin
        b_delay <= 2;
      end else if (b_delay > 0) begin
        b_delay <= b_delay - 1;
      end else if (b_delay == 0) begin
        bvalid  <= 1'b1;
        bid     <= id_q;
        bresp   <= resp_q;
        b_delay <= -1;
      end
    end
  end

endmodule

module tb_axi_write_xbar;

  import axi_pkg::*;

  localparam int FIELDS = 6;
  localparam int MAX_BURSTS = 32;
  localparam int STEP_LIMIT = 200;

  logic clk;
  logic rstn;
  addr_t awaddr_m1;
  id_t   awid_m1;
  logic  awvalid_m1, awready_m1;
  data_t wdata_m1;
  strb_t wstrb_m1;
  logic  wlast_m1, wvalid_m1, wready_m1;
  id_t   bid_m1;
  resp_t bresp_m1;
  logic  bvalid_m1, bready_m1;
  addr_t awaddr_s0, awaddr_s1, awaddr_s2;
  id_t   awid_s0, awid_s1, awid_s2;
  logic  awvalid_s0, awvalid_s1, awvalid_s2;
  logic  awready_s0, awready_s1, awready_s2;
  data_t wdata_s0, wdata_s1, wdata_s2;
  strb_t wstrb_s0, wstrb_s1, wstrb_s2;
  logic  wlast_s0, wlast_s1, wlast_s2;
  logic  wvalid_s0, wvalid_s1, wvalid_s2;
  logic  wready_s0, wready_s1, wready_s2;
  id_t   bid_s0, bid_s1, bid_s2;
  resp_t bresp_s0, bresp_s1, bresp_s2;
  logic  bvalid_s0, bvalid_s1, bvalid_s2;
  logic  bready_s0, bready_s1, bready_s2;
  logic [7:0] stall_pattern;
  resp_t resp_code;

  logic [31:0] stim [0:FIELDS*MAX_BURSTS-1];
  int nb;
  int errors;
  int bursts_done;
  int timeouts = 0;
  int seed;

  axi_write_xbar dut0 (.*);

  xbar_checker chk0 (.*, .write_pending(dut0.write_pending));

  slave_model slv0 (.clk, .rstn, .awvalid(awvalid_s0), .awid(awid_s0),
    .awready(awready_s0), .wvalid(wvalid_s0), .wlast(wlast_s0), .wready(wready_s0),
    .bid(bid_s0), .bresp(bresp_s0), .bvalid(bvalid_s0), .bready(bready_s0),
    .stall_pattern, .resp_code);
  slave_model slv1 (.clk, .rstn, .awvalid(awvalid_s1), .awid(awid_s1),
    .awready(awready_s1), .wvalid(wvalid_s1), .wlast(wlast_s1), .wready(wready_s1),
    .bid(bid_s1), .bresp(bresp_s1), .bvalid(bvalid_s1), .bready(bready_s1),
    .stall_pattern, .resp_code);
  slave_model slv2 (.clk, .rstn, .awvalid(awvalid_s2), .awid(awid_s2),
    .awready(awready_s2), .wvalid(wvalid_s2), .wlast(wlast_s2), .wready(wready_s2),
    .bid(bid_s2), .bresp(bresp_s2), .bvalid(bvalid_s2), .bready(bready_s2),
    .stall_pattern, .resp_code);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic drive_beat(input int base, input int k, input int beats);
    wvalid_m1 = 1'b1;
    wdata_m1  = stim[base+2] + 32'(k);
    wlast_m1  = (k == beats - 1);
    // Strobe field of zero asks for random strobes
    if (stim[base+5] != 0) begin
      wstrb_m1 = stim[base+5][3:0];
    end else begin
      wstrb_m1 = strb_t'($urandom);
    end
  endtask

  task automatic run_burst(input int i);
    int base;
    int beats;
    int beat;
    int steps;
    int w_wait;
    logic fast;
    logic aw_done;
    logic w_on;
    logic aw_hs;
    logic w_hs;
    base    = i * FIELDS;
    beats   = int'(stim[base+1]);
    fast    = (i % 2 == 0);
    beat    = 0;
    steps   = 0;
    w_wait  = 0;
    aw_done = 1'b0;
    w_on    = fast;
    @(negedge clk);
    awaddr_m1     = stim[base];
    awid_m1       = id_t'(i);
    awvalid_m1    = 1'b1;
    stall_pattern = stim[base+3][7:0];
    resp_code     = stim[base+4][1:0];
    if (fast) begin
      drive_beat(base, 0, beats);
    end
    while (!(aw_done && beat == beats)) begin
      @(posedge clk);
      aw_hs = awvalid_m1 && awready_m1;
      w_hs  = wvalid_m1 && wready_m1;
      @(negedge clk);
      if (aw_hs) begin
        aw_done    = 1'b1;
        awvalid_m1 = 1'b0;
      end
      if (w_hs) begin
        beat++;
        if (beat == beats) begin
          wvalid_m1 = 1'b0;
          wlast_m1  = 1'b0;
        end else begin
          drive_beat(base, beat, beats);
        end
      end else if (!w_on && aw_done) begin
        // Slow path, W follows AW by two cycles
        if (w_wait == 1) begin
          w_on = 1'b1;
          drive_beat(base, 0, beats);
        end else begin
          w_wait++;
        end
      end
      steps++;
      if (steps > STEP_LIMIT) begin
        $display("timeout waiting for AW or W handshakes of burst %0d", i);
        timeouts++;
        awvalid_m1 = 1'b0;
        wvalid_m1  = 1'b0;
        return;
      end
    end
  endtask

  initial begin
    int steps;
    rstn          = 1'b0;
    awaddr_m1     = '0;
    awid_m1       = '0;
    awvalid_m1    = 1'b0;
    wdata_m1      = '0;
    wstrb_m1      = '0;
    wlast_m1      = 1'b0;
    wvalid_m1     = 1'b0;
    bready_m1     = 1'b0;
    stall_pattern = '0;
    resp_code     = '0;
    seed = $urandom(32'hdb15);
    for (int i = 0; i < FIELDS * MAX_BURSTS; i++) begin
      stim[i] = '0;
    end
    $readmemh("verif/xbar_write_input.txt", stim);
    nb = 0;
    while (nb < MAX_BURSTS && stim[nb*FIELDS+1] != 0) begin
      nb++;
    end

    repeat (5) @(negedge clk);
    rstn      = 1'b1;
    bready_m1 = 1'b1;

    for (int i = 0; i < nb; i++) begin
      run_burst(i);
    end

    steps = 0;
    while (bursts_done < nb && steps <= STEP_LIMIT) begin
      @(negedge clk);
      steps++;
    end
    if (bursts_done < nb) begin
      $display("timeout waiting for BVALID");
      timeouts++;
    end
    repeat (2) @(negedge clk);

    $display("errors %0d, timeouts %0d, bursts %0d of %0d", errors, timeouts,
             bursts_done, nb);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
design/axi_pkg.sv
design/aw_decoder.sv
design/w_router.sv
design/b_return.sv
design/axi_write_xbar.sv
verif/xbar_checker.sv
verif/tb_axi_write_xbar.sv

//--- run.sh
#!/bin/sh
# Build and run the write crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_axi_write_xbar -f sim.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or simulation failed"; exit 1; }

grep -q "Test passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }

//--- verif/xbar_write_input.txt
// addr     beats first_data stall resp strb
// stall is an 8 bit WREADY stall mask, strb 0 picks random strobes per beat
00001000 4 a0000000 00 0 f
40002000 3 b1000010 a5 2 f
80000040 1 c2000000 00 0 3
c0000100 5 d3000000 36 1 0
00000200 2 e4000000 11 3 f
7ffffffc 6 f5000000 4a 0 c
40000010 1 16000000 01 2 f
bfff0000 3 27000000 0c 1 0
00000300 7 38000000 92 0 f
c0000004 2 49000000 00 3 f
